// ==== Bender.yml ====
package:
  name: dsi_tx

sources:
  - hw/dsi_tx_pkg.sv
  - hw/dsi_tx_regs.sv
  - hw/dsi_tx_pixel_buffer.sv
  - hw/dsi_tx_packet_assembler.sv
  - hw/dsi_tx_lane_distributor.sv
  - hw/dsi_tx_top.sv
  - target: test
    files:
      - dv/dsi_tx_tb.sv

// ==== dsi_tx_top.f ====
hw/dsi_tx_pkg.sv
hw/dsi_tx_regs.sv
hw/dsi_tx_pixel_buffer.sv
hw/dsi_tx_packet_assembler.sv
hw/dsi_tx_lane_distributor.sv
hw/dsi_tx_top.sv
dv/dsi_tx_tb.sv

// ==== dv/dsi_tx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_tb;

    localparam int LINE_WIDTH     = 8;
    localparam int BITS_PER_PIXEL = 8;
    localparam int FIFO_DEPTH     = 16;
    localparam int LINE_BYTES     = LINE_WIDTH * BITS_PER_PIXEL / 8;
    localparam int LINE_WORDS     = LINE_BYTES / 4;
    localparam int TIMEOUT        = 2000; // cycles per wait loop
    localparam logic [31:0] SEED  = 32'hedec_10fe;

    typedef struct {
        string       name;
        logic [1:0]  mode;
        logic [23:0] cmd;   // zero means no command in this row
        int          lines;
        bit          bp;
    } row_t;

    logic                   clk_sys;
    logic                   reset;
    dsi_tx_pkg::reg_req_t   reg_req;
    logic [31:0]            reg_rdata;
    logic                   irq;
    logic [31:0]            pix_data;
    logic                   pix_valid;
    logic                   pix_ready;
    dsi_tx_pkg::dsi_lanes_t hs_lanes;
    logic                   hs_valid;
    logic                   hs_ready;

    logic [9:0]  exp_q[$];     // {beat start, end of packet, byte}
    logic [9:0]  act_q[$];
    logic [31:0] line_words[$];
    logic [31:0] rng_state;
    logic [31:0] bp_state;
    bit          bp_mode;
    int          errors;
    row_t        rows[8];

    dsi_tx_top #(
        .LINE_WIDTH     (LINE_WIDTH),
        .BITS_PER_PIXEL (BITS_PER_PIXEL),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) DUT (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .reg_req   (reg_req),
        .reg_rdata (reg_rdata),
        .irq       (irq),
        .pix_data  (pix_data),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .hs_lanes  (hs_lanes),
        .hs_valid  (hs_valid),
        .hs_ready  (hs_ready)
    );

    always #5 clk_sys = ~clk_sys;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int lane_count(input logic [1:0] mode);
        case (mode)
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4; // mode 3 runs four lanes as well
        endcase
    endfunction

    // random ready on the output when the row asks for back-pressure
    always @(posedge clk_sys) begin
        #1;
        if (bp_mode) begin
            bp_state = xorshift(bp_state);
            hs_ready = bp_state[0];
        end else begin
            hs_ready = 1'b1;
        end
    end

    // beat signals are stable at the falling edge, ahead of the transfer edge
    always @(negedge clk_sys) begin : capture
        int top;
        if (!reset && hs_valid && hs_ready) begin
            top = 0;
            for (int k = 0; k < dsi_tx_pkg::LANES_MAX; k++) begin
                if (hs_lanes.lane_valid[k]) top = k;
            end
            for (int k = 0; k < dsi_tx_pkg::LANES_MAX; k++) begin
                if (hs_lanes.lane_valid[k]) begin
                    act_q.push_back({k == 0, hs_lanes.last && (k == top), hs_lanes.data[k]});
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
        reg_req = '{addr: addr, write: 1'b1, read: 1'b0, wdata: data};
        @(posedge clk_sys);
        #1;
        reg_req = '0;
    endtask

    task automatic reg_read(input logic [4:0] addr, output logic [31:0] data);
        reg_req = '{addr: addr, write: 1'b0, read: 1'b1, wdata: 32'd0};
        @(posedge clk_sys);
        #1;
        reg_req = '0;
        data    = reg_rdata;
    endtask

    task automatic push_word(input logic [31:0] w);
        int t;
        t         = 0;
        pix_data  = w;
        pix_valid = 1'b1;
        @(negedge clk_sys);
        while (!pix_ready && t < TIMEOUT) begin
            @(negedge clk_sys);
            t++;
        end
        if (!pix_ready) begin
            $display("timeout: the pixel buffer never accepted a word");
            errors++;
        end
        @(posedge clk_sys);
        #1;
        pix_valid = 1'b0;
    endtask

    // bytes of one word in lane order, a new beat every n bytes
    task automatic model_word(input logic [31:0] data, input int nb, input bit last,
                              input int n);
        for (int i = 0; i < nb; i++) begin
            exp_q.push_back({(i % n) == 0, last && (i == nb - 1), data[8*i +: 8]});
        end
    endtask

    task automatic model_cmd(input logic [23:0] cmd, input int n);
        model_word({cmd[7:0] ^ cmd[15:8] ^ cmd[23:16], cmd}, 4, 1'b1, n);
    endtask

    task automatic model_line(input int n);
        logic [15:0] sum;
        logic [23:0] hdr;
        sum = '0;
        hdr = {16'(LINE_BYTES), dsi_tx_pkg::DT_PIXEL_STREAM};
        model_word({hdr[7:0] ^ hdr[15:8] ^ hdr[23:16], hdr}, 4, 1'b0, n);
        foreach (line_words[i]) begin
            model_word(line_words[i], 4, 1'b0, n);
            for (int b = 0; b < 4; b++) sum += line_words[i][8*b +: 8];
        end
        model_word({16'd0, sum}, 2, 1'b1, n); // footer, low byte first
        line_words.delete();
    endtask

    task automatic wait_cmd_done(input string name);
        logic [31:0] v;
        int          t;
        v = '0;
        t = 0;
        while (!v[0] && t < TIMEOUT) begin
            reg_read(dsi_tx_pkg::REG_STATUS, v);
            t++;
        end
        if (!v[0]) begin
            $display("timeout: the command of %s never completed", name);
            errors++;
        end
    endtask

    task automatic wait_bytes(input string name);
        int t;
        t = 0;
        while (act_q.size() < exp_q.size() && t < TIMEOUT) begin
            @(posedge clk_sys);
            #1;
            t++;
        end
        if (act_q.size() < exp_q.size()) begin
            $display("timeout: %s received too few bytes on the lanes", name);
            errors++;
        end
        repeat (4) @(posedge clk_sys); // let any extra beats show up
        #1;
    endtask

    task automatic compare_streams(input string name);
        int n;
        check_value({name, " byte count"}, exp_q.size(), act_q.size());
        n = (exp_q.size() < act_q.size()) ? exp_q.size() : act_q.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("%s byte %0d", name, i), 32'(exp_q[i]), 32'(act_q[i]));
        end
        exp_q.delete();
        act_q.delete();
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] v;
        logic [31:0] count0;
        int          n;
        n       = lane_count(r.mode);
        bp_mode = r.bp;
        reg_read(dsi_tx_pkg::REG_LINE_COUNT, count0);
        reg_write(dsi_tx_pkg::REG_CTRL, {29'd0, r.mode, 1'b1});
        if (r.cmd != '0) begin
            model_cmd(r.cmd, n);
            reg_write(dsi_tx_pkg::REG_CMD, {8'd0, r.cmd});
            wait_cmd_done(r.name);
            check_value({r.name, " irq set"}, 32'd1, irq);
            reg_write(dsi_tx_pkg::REG_STATUS, 32'd1);
            reg_read(dsi_tx_pkg::REG_STATUS, v);
            check_value({r.name, " status cleared"}, 32'd0, v);
            check_value({r.name, " irq cleared"}, 32'd0, irq);
        end
        for (int l = 0; l < r.lines; l++) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                rng_state = xorshift(rng_state);
                line_words.push_back(rng_state);
                push_word(rng_state);
            end
            model_line(n);
        end
        wait_bytes(r.name);
        compare_streams(r.name);
        reg_read(dsi_tx_pkg::REG_LINE_COUNT, v);
        check_value({r.name, " line count"}, count0 + r.lines, v);
        bp_mode = 1'b0;
    endtask

    // fill the buffer while disabled, then let it drain as whole lines
    task automatic fill_and_drain();
        logic [31:0] v;
        logic [31:0] count0;
        bp_mode = 1'b1;
        reg_read(dsi_tx_pkg::REG_LINE_COUNT, count0);
        reg_write(dsi_tx_pkg::REG_CTRL, 32'h4);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            rng_state = xorshift(rng_state);
            line_words.push_back(rng_state);
            push_word(rng_state);
            if (line_words.size() == LINE_WORDS) model_line(4);
        end
        @(negedge clk_sys);
        check_value("fill pix_ready low", 32'd0, pix_ready);
        check_value("fill no output", 32'd0, act_q.size());
        @(posedge clk_sys);
        #1;
        reg_write(dsi_tx_pkg::REG_CTRL, 32'h5);
        wait_bytes("fill_drain");
        compare_streams("fill_drain");
        reg_read(dsi_tx_pkg::REG_LINE_COUNT, v);
        check_value("fill_drain line count", count0 + FIFO_DEPTH / LINE_WORDS, v);
        bp_mode = 1'b0;
    endtask

    initial begin
        logic [31:0] v;
        clk_sys   = 1'b0;
        reset     = 1'b1;
        reg_req   = '0;
        pix_data  = '0;
        pix_valid = 1'b0;
        hs_ready  = 1'b1;
        bp_mode   = 1'b0;
        errors    = 0;
        rng_state = SEED;
        bp_state  = SEED;
        rows[0] = '{"cmd_lanes_1", 2'd0, 24'h00_29_05, 0, 1'b0};
        rows[1] = '{"cmd_lanes_2", 2'd1, 24'h01_36_15, 0, 1'b0};
        rows[2] = '{"cmd_lanes_4", 2'd2, 24'h00_11_05, 0, 1'b0};
        rows[3] = '{"line_lanes_1", 2'd0, 24'h0, 2, 1'b0};
        rows[4] = '{"line_lanes_2", 2'd1, 24'h0, 2, 1'b0};
        rows[5] = '{"line_lanes_4", 2'd2, 24'h0, 2, 1'b0};
        rows[6] = '{"bp_mode3_mixed", 2'd3, 24'h5a_51_15, 3, 1'b1};
        rows[7] = '{"bp_lanes_2_mixed", 2'd1, 24'h00_28_05, 2, 1'b1};

        repeat (2) @(posedge clk_sys);
        #1;
        reset = 1'b0;

        check_value("reset hs_valid", 32'd0, hs_valid);
        check_value("reset irq", 32'd0, irq);
        check_value("reset pix_ready", 32'd1, pix_ready);
        reg_read(dsi_tx_pkg::REG_CTRL, v);
        check_value("reset ctrl", 32'd0, v);
        reg_read(dsi_tx_pkg::REG_STATUS, v);
        check_value("reset status", 32'd0, v);
        reg_read(dsi_tx_pkg::REG_LINE_COUNT, v);
        check_value("reset line count", 32'd0, v);
        reg_read(5'd17, v); // not in the register map
        check_value("unmapped read", 32'd0, v);

        reg_write(dsi_tx_pkg::REG_CTRL, 32'h2);
        reg_read(dsi_tx_pkg::REG_CTRL, v);
        check_value("ctrl readback", 32'h2, v);
        reg_write(dsi_tx_pkg::REG_IRQ_EN, 32'h1);
        reg_read(dsi_tx_pkg::REG_IRQ_EN, v);
        check_value("irq_en readback", 32'h1, v);

        foreach (rows[i]) run_row(rows[i]);
        fill_and_drain();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/dsi_tx_lane_distributor.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_lane_distributor (
    input  wire                        clk_sys,
    input  wire                        reset,
    input  var dsi_tx_pkg::lane_mode_e lane_mode,
    input  var dsi_tx_pkg::dsi_word_t  asm_word,
    input  wire                        asm_valid,
    output logic                       asm_ready,
    output dsi_tx_pkg::dsi_lanes_t     hs_lanes,
    output logic                       hs_valid,
    input  wire                        hs_ready
);

    dsi_tx_pkg::dsi_word_t hold;
    logic [2:0]  offset;     // first byte of the current beat
    logic [2:0]  lane_cnt;   // lanes in use, latched with the word
    logic [2:0]  mode_lanes;
    logic [3:0]  beat_end;
    logic        final_beat;
    logic [31:0] shifted;

    always_comb begin
        case (lane_mode)
            dsi_tx_pkg::LANES_1: mode_lanes = 3'd1;
            dsi_tx_pkg::LANES_2: mode_lanes = 3'd2;
            default:             mode_lanes = 3'd4;
        endcase
    end

    assign beat_end   = {1'b0, offset} + {1'b0, lane_cnt};
    assign final_beat = (beat_end >= {1'b0, hold.nbytes});
    assign shifted    = hold.data >> {offset, 3'b000};
    assign asm_ready  = !hs_valid || (hs_ready && final_beat);

    always_comb begin
        for (int k = 0; k < dsi_tx_pkg::LANES_MAX; k++) begin
            hs_lanes.lane_valid[k] = (k < int'(lane_cnt)) &&
                                     ((int'(offset) + k) < int'(hold.nbytes));
            hs_lanes.data[k]       = hs_lanes.lane_valid[k] ? shifted[8*k +: 8] : 8'h00;
        end
        hs_lanes.last = hold.last && final_beat;
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_valid <= 1'b0;
            offset   <= '0;
            lane_cnt <= 3'd1;
        end else if (asm_valid && asm_ready) begin
            hs_valid <= 1'b1;
            offset   <= '0;        // every word starts a fresh beat
            lane_cnt <= mode_lanes;
        end else if (hs_valid && hs_ready) begin
            if (final_beat) begin
                hs_valid <= 1'b0;
            end else begin
                offset <= beat_end[2:0];
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (asm_valid && asm_ready) begin
            hold <= asm_word;
        end
    end

    a_lane_range: assert property (@(posedge clk_sys) disable iff (reset)
        hs_valid |-> hs_lanes.lane_valid[0] && ((hs_lanes.lane_valid >> lane_cnt) == '0));

endmodule

`default_nettype wire

// ==== hw/dsi_tx_packet_assembler.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_packet_assembler #(
    parameter int LINE_WIDTH     = 640,
    parameter int BITS_PER_PIXEL = 8
) (
    input  wire                     clk_sys,
    input  wire                     reset,
    input  wire                     enable,
    input  wire                     cmd_valid,
    output logic                    cmd_ready,
    input  wire  [23:0]             cmd_packet,
    input  wire  [31:0]             buf_word,
    input  wire                     buf_valid,
    output logic                    buf_ready,
    input  wire                     line_ready,
    output dsi_tx_pkg::dsi_word_t   asm_word,
    output logic                    asm_valid,
    input  wire                     asm_ready,
    output logic                    cmd_sent,
    output logic                    line_sent
);

    localparam int LINE_BYTES = LINE_WIDTH * BITS_PER_PIXEL / 8;
    localparam int LINE_WORDS = LINE_BYTES / 4;
    localparam int CW         = $clog2(LINE_WORDS + 1);

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        HEADER,
        PAYLOAD,
        FOOTER
    } asm_state_e;

    asm_state_e    state;
    logic [CW-1:0] word_cnt;    // payload words fetched so far
    logic [15:0]   byte_sum;
    logic          in_line;
    logic          can_load;
    logic          all_fetched;
    logic          start_cmd;
    logic          start_line;
    logic          fetch;
    logic          load_footer;

    // three header bytes plus their xor check byte
    function automatic logic [31:0] add_check(input logic [23:0] hdr);
        return {hdr[23:16] ^ hdr[15:8] ^ hdr[7:0], hdr};
    endfunction

    function automatic logic [15:0] word_sum(input logic [31:0] w);
        return 16'(w[7:0]) + 16'(w[15:8]) + 16'(w[23:16]) + 16'(w[31:24]);
    endfunction

    assign in_line     = (state == HEADER) || (state == PAYLOAD);
    assign can_load    = !asm_valid || asm_ready; // output slot free at this edge
    assign all_fetched = (word_cnt == CW'(LINE_WORDS));
    assign start_cmd   = (state == IDLE) && enable && cmd_valid; // commands go first
    assign start_line  = (state == IDLE) && enable && !cmd_valid && line_ready;
    assign fetch       = in_line && can_load && !all_fetched && buf_valid;
    assign load_footer = in_line && can_load && all_fetched;

    assign cmd_ready = start_cmd;
    assign buf_ready = fetch;
    assign cmd_sent  = (state == CMD) && asm_valid && asm_ready;
    assign line_sent = (state == FOOTER) && asm_valid && asm_ready;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state     <= IDLE;
            asm_valid <= 1'b0;
            word_cnt  <= '0;
            byte_sum  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_cmd) begin
                        asm_valid <= 1'b1;
                        state     <= CMD;
                    end else if (start_line) begin
                        asm_valid <= 1'b1;
                        word_cnt  <= '0;
                        byte_sum  <= '0;
                        state     <= HEADER;
                    end
                end
                CMD, FOOTER: begin
                    if (asm_ready) begin
                        asm_valid <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: begin
                    if (fetch) begin
                        asm_valid <= 1'b1;
                        word_cnt  <= word_cnt + 1'b1;
                        byte_sum  <= byte_sum + word_sum(buf_word);
                        state     <= PAYLOAD;
                    end else if (load_footer) begin
                        asm_valid <= 1'b1;
                        state     <= FOOTER;
                    end else if (asm_ready) begin
                        asm_valid <= 1'b0; // waiting on the buffer
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (start_cmd) begin
            asm_word <= '{data: add_check(cmd_packet), nbytes: 3'd4, last: 1'b1};
        end else if (start_line) begin
            asm_word <= '{data: add_check({16'(LINE_BYTES), dsi_tx_pkg::DT_PIXEL_STREAM}),
                          nbytes: 3'd4, last: 1'b0};
        end else if (fetch) begin
            asm_word <= '{data: buf_word, nbytes: 3'd4, last: 1'b0};
        end else if (load_footer) begin
            asm_word <= '{data: {16'd0, byte_sum}, nbytes: 3'd2, last: 1'b1}; // sum low byte first
        end
    end

    // pixel lines must fill whole words
    a_line_bytes: assert property (@(posedge clk_sys) (LINE_BYTES % 4) == 0);

    a_word_hold: assert property (@(posedge clk_sys) disable iff (reset)
        asm_valid && !asm_ready |=> asm_valid && $stable(asm_word));

endmodule

`default_nettype wire

// ==== hw/dsi_tx_pixel_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_pixel_buffer #(
    parameter int LINE_WIDTH     = 640,
    parameter int BITS_PER_PIXEL = 8,
    parameter int FIFO_DEPTH     = 1024
) (
    input  wire         clk_sys,
    input  wire         reset,
    input  wire  [31:0] pix_data,
    input  wire         pix_valid,
    output logic        pix_ready,
    output logic [31:0] buf_word,
    output logic        buf_valid,
    input  wire         buf_ready,
    output logic        line_ready
);

    localparam int LINE_WORDS = LINE_WIDTH * BITS_PER_PIXEL / 32;
    localparam int AW         = $clog2(FIFO_DEPTH);
    localparam int CW         = $clog2(FIFO_DEPTH + 1);

    logic [31:0]   mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;   // words stored
    logic          push;
    logic          pop;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pix_ready = (count != CW'(FIFO_DEPTH));
    assign buf_valid = (count != '0);
    assign buf_word  = mem[rd_ptr]; // first-word fall-through
    assign push      = pix_valid && pix_ready;
    assign pop       = buf_valid && buf_ready;

    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem[wr_ptr] <= pix_data;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            line_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count      <= count + CW'(push) - CW'(pop);
            line_ready <= (count >= CW'(LINE_WORDS)); // one full line stored
        end
    end

    // a full buffer has its write pointer wrapped onto the read pointer
    a_no_overflow: assert property (@(posedge clk_sys) disable iff (reset)
        (count == CW'(FIFO_DEPTH)) |-> (wr_ptr == rd_ptr));

    // the assembler pulls only when a word is stored
    a_no_underflow: assert property (@(posedge clk_sys) disable iff (reset)
        buf_ready |-> buf_valid);

endmodule

`default_nettype wire

// ==== hw/dsi_tx_pkg.sv ====
`default_nettype none

package dsi_tx_pkg;

    localparam int LANES_MAX = 4; // data lanes on the output stream

    typedef enum logic [4:0] {
        REG_CTRL       = 5'd0, // enable, lane mode
        REG_CMD        = 5'd1, // a write sends one short packet
        REG_STATUS     = 5'd2, // cmd_done (w1c), cmd_busy
        REG_IRQ_EN     = 5'd3,
        REG_LINE_COUNT = 5'd4  // read only
    } reg_addr_e;

    typedef enum logic [1:0] {
        LANES_1 = 2'd0,
        LANES_2 = 2'd1,
        LANES_4 = 2'd2  // 3 also means four lanes
    } lane_mode_e;

    typedef enum logic [7:0] {
        DT_DCS_SHORT_WRITE = 8'h05,
        DT_DCS_SHORT_PARAM = 8'h15,
        DT_DCS_LONG_WRITE  = 8'h39,
        DT_PIXEL_STREAM    = 8'h3E  // one pixel line per packet
    } dsi_data_type_e;

    typedef struct packed {
        logic [4:0]  addr;
        logic        write;
        logic        read;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] data;   // byte 0 in bits 7:0
        logic [2:0]  nbytes; // valid bytes from byte 0 up
        logic        last;   // end of packet
    } dsi_word_t;

    typedef struct packed {
        logic [LANES_MAX-1:0][7:0] data;
        logic [LANES_MAX-1:0]      lane_valid;
        logic                      last;
    } dsi_lanes_t;

endpackage

`default_nettype wire

// ==== hw/dsi_tx_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_regs (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  var dsi_tx_pkg::reg_req_t reg_req,
    output logic [31:0]              reg_rdata,
    output logic                     irq,
    output logic                     enable,
    output dsi_tx_pkg::lane_mode_e   lane_mode,
    output logic                     cmd_valid,
    input  wire                      cmd_ready,
    output logic [23:0]              cmd_packet,
    input  wire                      cmd_sent,
    input  wire                      line_sent
);

    logic        cmd_busy;
    logic        cmd_done;
    logic        irq_en;
    logic [15:0] line_count;
    logic        cmd_load;
    logic        done_clear;

    // a new command is taken only when none is in flight
    assign cmd_load   = reg_req.write && (reg_req.addr == dsi_tx_pkg::REG_CMD) && !cmd_busy;
    assign done_clear = reg_req.write && (reg_req.addr == dsi_tx_pkg::REG_STATUS) &&
                        reg_req.wdata[0];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            enable    <= 1'b0;
            lane_mode <= dsi_tx_pkg::LANES_1;
            irq_en    <= 1'b0;
        end else if (reg_req.write) begin
            case (reg_req.addr)
                dsi_tx_pkg::REG_CTRL: begin
                    enable    <= reg_req.wdata[0];
                    lane_mode <= dsi_tx_pkg::lane_mode_e'(reg_req.wdata[2:1]);
                end
                dsi_tx_pkg::REG_IRQ_EN: begin
                    irq_en <= reg_req.wdata[0];
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cmd_valid <= 1'b0;
            cmd_busy  <= 1'b0;
        end else if (cmd_load) begin
            cmd_valid <= 1'b1;
            cmd_busy  <= 1'b1;
        end else begin
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0; // taken by the assembler
            end
            if (cmd_sent) begin
                cmd_busy <= 1'b0;  // last word left the assembler
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (cmd_load) begin
            cmd_packet <= reg_req.wdata[23:0];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cmd_done   <= 1'b0;
            line_count <= '0;
            irq        <= 1'b0;
        end else begin
            if (cmd_sent) begin
                cmd_done <= 1'b1;
            end else if (done_clear) begin
                cmd_done <= 1'b0;
            end
            if (line_sent) begin
                line_count <= line_count + 16'd1;
            end
            irq <= cmd_done && irq_en;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            reg_rdata <= '0;
        end else if (reg_req.read) begin
            case (reg_req.addr)
                dsi_tx_pkg::REG_CTRL:       reg_rdata <= {29'd0, lane_mode, enable};
                dsi_tx_pkg::REG_CMD:        reg_rdata <= {8'd0, cmd_packet};
                dsi_tx_pkg::REG_STATUS:     reg_rdata <= {30'd0, cmd_busy, cmd_done};
                dsi_tx_pkg::REG_IRQ_EN:     reg_rdata <= {31'd0, irq_en};
                dsi_tx_pkg::REG_LINE_COUNT: reg_rdata <= {16'd0, line_count};
                default:                    reg_rdata <= '0;
            endcase
        end
    end

    // the assembler must see the same packet until it takes it
    a_cmd_stable: assert property (@(posedge clk_sys) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_packet));

endmodule

`default_nettype wire

// ==== hw/dsi_tx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_top #(
    parameter int LINE_WIDTH     = 640,
    parameter int BITS_PER_PIXEL = 8,
    parameter int FIFO_DEPTH     = 1024
) (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  var dsi_tx_pkg::reg_req_t reg_req,
    output logic [31:0]              reg_rdata,
    output logic                     irq,
    input  wire  [31:0]              pix_data,
    input  wire                      pix_valid,
    output logic                     pix_ready,
    output dsi_tx_pkg::dsi_lanes_t   hs_lanes,
    output logic                     hs_valid,
    input  wire                      hs_ready
);

    logic                   enable;
    dsi_tx_pkg::lane_mode_e lane_mode;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic [23:0]            cmd_packet;
    logic                   cmd_sent;
    logic                   line_sent;
    logic [31:0]            buf_word;
    logic                   buf_valid;
    logic                   buf_ready;
    logic                   line_ready;
    dsi_tx_pkg::dsi_word_t  asm_word;
    logic                   asm_valid;
    logic                   asm_ready;

    dsi_tx_regs dsi_tx_regs_0 (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .reg_req    (reg_req),
        .reg_rdata  (reg_rdata),
        .irq        (irq),
        .enable     (enable),
        .lane_mode  (lane_mode),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_packet (cmd_packet),
        .cmd_sent   (cmd_sent),
        .line_sent  (line_sent)
    );

    dsi_tx_pixel_buffer #(
        .LINE_WIDTH     (LINE_WIDTH),
        .BITS_PER_PIXEL (BITS_PER_PIXEL),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) dsi_tx_pixel_buffer_0 (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .pix_data   (pix_data),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .buf_word   (buf_word),
        .buf_valid  (buf_valid),
        .buf_ready  (buf_ready),
        .line_ready (line_ready)
    );

    dsi_tx_packet_assembler #(
        .LINE_WIDTH     (LINE_WIDTH),
        .BITS_PER_PIXEL (BITS_PER_PIXEL)
    ) dsi_tx_packet_assembler_0 (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .enable     (enable),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_packet (cmd_packet),
        .buf_word   (buf_word),
        .buf_valid  (buf_valid),
        .buf_ready  (buf_ready),
        .line_ready (line_ready),
        .asm_word   (asm_word),
        .asm_valid  (asm_valid),
        .asm_ready  (asm_ready),
        .cmd_sent   (cmd_sent),
        .line_sent  (line_sent)
    );

    dsi_tx_lane_distributor dsi_tx_lane_distributor_0 (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .lane_mode (lane_mode),
        .asm_word  (asm_word),
        .asm_valid (asm_valid),
        .asm_ready (asm_ready),
        .hs_lanes  (hs_lanes),
        .hs_valid  (hs_valid),
        .hs_ready  (hs_ready)
    );

endmodule

`default_nettype wire
